// ==== verilog/rop_consts.svh ====
`ifndef ROP_CONSTS_SVH
`define ROP_CONSTS_SVH

// ------------------------------------------------------------
// slice layout.
// ------------------------------------------------------------

`define ROP_NUM_SLICES 4
`define ROP_SLICE_BITS 2    // also the width of a memory tag.

// ------------------------------------------------------------
// data path and counter widths.
// ------------------------------------------------------------

`define ROP_ADDR_BITS 16    // word address.
`define ROP_COLOR_BITS 32   // rgba, 8 bits per channel.
`define ROP_PERF_CTR_BITS 32

`endif

// ==== verilog/rop_pkg.sv ====
`include "rop_consts.svh"

package rop_pkg;

    typedef logic [`ROP_ADDR_BITS-1:0] rop_addr_t;
    typedef logic [`ROP_COLOR_BITS-1:0] rop_color_t;   // channel 0 sits in the low byte.
    typedef logic [`ROP_SLICE_BITS-1:0] rop_tag_t;     // a tag is the index of a slice.
    typedef logic [`ROP_PERF_CTR_BITS-1:0] rop_ctr_t;

    typedef enum logic [1:0] {
        blend_replace = 2'd0,
        blend_add = 2'd1,     // saturating per channel.
        blend_xor = 2'd2
    } rop_blend_t;

    // read-modify-write steps of one slice.
    typedef enum logic [1:0] {
        slice_idle = 2'd0,
        slice_read = 2'd1,
        slice_wait_rsp = 2'd2,
        slice_write = 2'd3
    } rop_slice_state_t;

endpackage

// ==== verilog/rop_req_demux.sv ====
`timescale 1ns/1ps
`include "rop_consts.svh"

module rop_req_demux
    import rop_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic req_valid,
    input rop_addr_t req_addr,
    input rop_color_t req_color,
    output logic req_ready,
    output logic [`ROP_NUM_SLICES-1:0] slice_req_valid,
    output rop_addr_t slice_req_addr [`ROP_NUM_SLICES],
    output rop_color_t slice_req_color [`ROP_NUM_SLICES],
    input logic [`ROP_NUM_SLICES-1:0] slice_req_ready
);

    rop_tag_t sel;
    logic run_q;

    // the low address bits pick the slice, so one address always lands in one slice.
    assign sel = req_addr[`ROP_SLICE_BITS-1:0];

    // a full register only blocks requests aimed at its own slice.
    assign req_ready = run_q & (~slice_req_valid[sel] | slice_req_ready[sel]);

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;    // holds off requests for the first cycle after reset.
        end
    end

    // ------------------------------------------------------------
    // one output register per slice.
    // ------------------------------------------------------------

    for (genvar i = 0; i < `ROP_NUM_SLICES; i++) begin : g_slot
        always_ff @(posedge clk) begin
            if (reset) begin
                slice_req_valid[i] <= 1'b0;
            end else if (req_valid && req_ready && sel == rop_tag_t'(i)) begin
                slice_req_valid[i] <= 1'b1;
            end else if (slice_req_ready[i]) begin
                slice_req_valid[i] <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (req_valid && req_ready && sel == rop_tag_t'(i)) begin
                slice_req_addr[i] <= req_addr;
                slice_req_color[i] <= req_color;
            end
        end

        // a held request must belong to the slice it is parked in.
        a_slot_addr : assert property (@(posedge clk) disable iff (reset)
            slice_req_valid[i] |-> slice_req_addr[i][`ROP_SLICE_BITS-1:0] == rop_tag_t'(i));
    end

endmodule

// ==== verilog/rop_slice.sv ====
`timescale 1ns/1ps

module rop_slice
    import rop_pkg::*;
(
    input logic clk,
    input logic reset,
    input rop_blend_t blend_mode,
    input logic req_valid,
    input rop_addr_t req_addr,
    input rop_color_t req_color,
    output logic req_ready,
    output logic mem_req_valid,
    output logic mem_req_rw,
    output rop_addr_t mem_req_addr,
    output rop_color_t mem_req_data,
    input logic mem_req_ready,
    input logic mem_rsp_valid,
    input rop_color_t mem_rsp_data,
    output logic mem_rsp_ready
);

    rop_slice_state_t state;
    rop_addr_t addr_q;
    rop_color_t color_q;    // the incoming pixel color.
    rop_color_t old_q;      // the color read back from memory.
    rop_blend_t mode_q;
    rop_color_t blend_color;

    // each 8 bit channel clips at 0xff instead of wrapping.
    function automatic rop_color_t sat_add(input rop_color_t a, input rop_color_t b);
        logic [8:0] sum;
        rop_color_t res;
        for (int c = 0; c < 4; c++) begin
            sum = {1'b0, a[c*8 +: 8]} + {1'b0, b[c*8 +: 8]};
            res[c*8 +: 8] = sum[8] ? 8'hff : sum[7:0];
        end
        return res;
    endfunction

    always_comb begin
        case (mode_q)
            blend_add: blend_color = sat_add(old_q, color_q);
            blend_xor: blend_color = old_q ^ color_q;
            default: blend_color = color_q;
        endcase
    end

    assign req_ready = (state == slice_idle);
    assign mem_req_valid = (state == slice_read) || (state == slice_write);
    assign mem_req_rw = (state == slice_write);
    assign mem_req_addr = addr_q;
    assign mem_req_data = blend_color;
    assign mem_rsp_ready = (state == slice_wait_rsp);

    // ------------------------------------------------------------
    // read-modify-write FSM, one pixel at a time.
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= slice_idle;
        end else begin
            case (state)
                slice_idle: begin
                    if (req_valid) begin
                        // replace needs nothing from memory.
                        state <= (blend_mode == blend_replace) ? slice_write : slice_read;
                    end
                end
                slice_read: begin
                    if (mem_req_ready) state <= slice_wait_rsp;
                end
                slice_wait_rsp: begin
                    if (mem_rsp_valid) state <= slice_write;
                end
                slice_write: begin
                    if (mem_req_ready) state <= slice_idle;   // pixel done.
                end
                default: state <= slice_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            addr_q <= req_addr;
            color_q <= req_color;
            mode_q <= blend_mode;
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            old_q <= mem_rsp_data;
        end
    end

    // the mux must only route a response to the slice that asked for it.
    a_rsp_in_wait : assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid |-> state == slice_wait_rsp);

endmodule

// ==== verilog/rop_mem_mux.sv ====
`timescale 1ns/1ps
`include "rop_consts.svh"

module rop_mem_mux
    import rop_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic [`ROP_NUM_SLICES-1:0] slice_mem_req_valid,
    input logic [`ROP_NUM_SLICES-1:0] slice_mem_req_rw,
    input rop_addr_t slice_mem_req_addr [`ROP_NUM_SLICES],
    input rop_color_t slice_mem_req_data [`ROP_NUM_SLICES],
    output logic [`ROP_NUM_SLICES-1:0] slice_mem_req_ready,
    output logic [`ROP_NUM_SLICES-1:0] slice_mem_rsp_valid,
    output rop_color_t slice_mem_rsp_data [`ROP_NUM_SLICES],
    input logic [`ROP_NUM_SLICES-1:0] slice_mem_rsp_ready,
    output logic mem_req_valid,
    output logic mem_req_rw,
    output rop_addr_t mem_req_addr,
    output rop_color_t mem_req_data,
    output rop_tag_t mem_req_tag,
    input logic mem_req_ready,
    input logic mem_rsp_valid,
    input rop_color_t mem_rsp_data,
    input rop_tag_t mem_rsp_tag,
    output logic mem_rsp_ready
);

    rop_tag_t last_q;
    rop_tag_t grant;
    rop_tag_t cand;
    logic found;

    // ------------------------------------------------------------
    // round-robin request arbitration.
    // ------------------------------------------------------------

    // search starts at the slice after the last winner.
    always_comb begin
        grant = last_q;
        found = 1'b0;
        cand = last_q;
        for (int k = 1; k <= `ROP_NUM_SLICES; k++) begin
            cand = last_q + rop_tag_t'(k);
            if (!found && slice_mem_req_valid[cand]) begin
                grant = cand;
                found = 1'b1;
            end
        end
    end

    assign mem_req_valid = found;
    assign mem_req_rw = slice_mem_req_rw[grant];
    assign mem_req_addr = slice_mem_req_addr[grant];
    assign mem_req_data = slice_mem_req_data[grant];
    assign mem_req_tag = grant;     // the tag brings a read response home.

    always_ff @(posedge clk) begin
        if (reset) begin
            last_q <= rop_tag_t'(`ROP_NUM_SLICES - 1);   // slice 0 goes first.
        end else if (mem_req_valid && mem_req_ready) begin
            last_q <= grant;
        end
    end

    // ------------------------------------------------------------
    // per-slice ready and response steering.
    // ------------------------------------------------------------

    for (genvar i = 0; i < `ROP_NUM_SLICES; i++) begin : g_port
        assign slice_mem_req_ready[i] = found && (grant == rop_tag_t'(i)) && mem_req_ready;
        assign slice_mem_rsp_valid[i] = mem_rsp_valid && (mem_rsp_tag == rop_tag_t'(i));
        assign slice_mem_rsp_data[i] = mem_rsp_data;
    end

    assign mem_rsp_ready = slice_mem_rsp_ready[mem_rsp_tag];

    // slices hold their request until it transfers.
    a_req_hold : assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid);

endmodule

// ==== verilog/rop_perf.sv ====
`timescale 1ns/1ps

module rop_perf
    import rop_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic req_valid,
    input logic req_ready,
    input logic mem_req_valid,
    input logic mem_req_rw,
    input logic mem_req_ready,
    input logic mem_rsp_valid,
    input logic mem_rsp_ready,
    output rop_ctr_t perf_mem_reads,
    output rop_ctr_t perf_mem_writes,
    output rop_ctr_t perf_mem_latency,
    output rop_ctr_t perf_idle_cycles,
    output rop_ctr_t perf_stall_cycles
);

    logic rd_fire;
    logic wr_fire;
    logic rsp_fire;
    logic idle_cycle;
    logic stall_cycle;
    rop_ctr_t pending_reads;

    assign rd_fire = mem_req_valid & mem_req_ready & ~mem_req_rw;
    assign wr_fire = mem_req_valid & mem_req_ready & mem_req_rw;
    assign rsp_fire = mem_rsp_valid & mem_rsp_ready;
    assign idle_cycle = ~req_valid & req_ready;
    assign stall_cycle = req_valid & ~req_ready;

    // ------------------------------------------------------------
    // counters, updated one edge after the event.
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads <= '0;
            perf_mem_reads <= '0;
            perf_mem_writes <= '0;
            perf_mem_latency <= '0;
            perf_idle_cycles <= '0;
            perf_stall_cycles <= '0;
        end else begin
            pending_reads <= pending_reads + rop_ctr_t'(rd_fire) - rop_ctr_t'(rsp_fire);
            perf_mem_reads <= perf_mem_reads + rop_ctr_t'(rd_fire);
            perf_mem_writes <= perf_mem_writes + rop_ctr_t'(wr_fire);
            // every outstanding read adds one cycle of latency.
            perf_mem_latency <= perf_mem_latency + pending_reads;
            perf_idle_cycles <= perf_idle_cycles + rop_ctr_t'(idle_cycle);
            perf_stall_cycles <= perf_stall_cycles + rop_ctr_t'(stall_cycle);
        end
    end

endmodule

// ==== verilog/rop_unit.sv ====
`timescale 1ns/1ps
`include "rop_consts.svh"

module rop_unit
    import rop_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic req_valid,
    input rop_addr_t req_addr,
    input rop_color_t req_color,
    output logic req_ready,
    input rop_blend_t blend_mode,
    output logic mem_req_valid,
    output logic mem_req_rw,
    output rop_addr_t mem_req_addr,
    output rop_color_t mem_req_data,
    output rop_tag_t mem_req_tag,
    input logic mem_req_ready,
    input logic mem_rsp_valid,
    input rop_color_t mem_rsp_data,
    input rop_tag_t mem_rsp_tag,
    output logic mem_rsp_ready,
    output rop_ctr_t perf_mem_reads,
    output rop_ctr_t perf_mem_writes,
    output rop_ctr_t perf_mem_latency,
    output rop_ctr_t perf_idle_cycles,
    output rop_ctr_t perf_stall_cycles
);

    // demux to slices.
    logic [`ROP_NUM_SLICES-1:0] slice_req_valid;
    rop_addr_t slice_req_addr [`ROP_NUM_SLICES];
    rop_color_t slice_req_color [`ROP_NUM_SLICES];
    logic [`ROP_NUM_SLICES-1:0] slice_req_ready;

    // slices to memory mux.
    logic [`ROP_NUM_SLICES-1:0] slice_mem_req_valid;
    logic [`ROP_NUM_SLICES-1:0] slice_mem_req_rw;
    rop_addr_t slice_mem_req_addr [`ROP_NUM_SLICES];
    rop_color_t slice_mem_req_data [`ROP_NUM_SLICES];
    logic [`ROP_NUM_SLICES-1:0] slice_mem_req_ready;
    logic [`ROP_NUM_SLICES-1:0] slice_mem_rsp_valid;
    rop_color_t slice_mem_rsp_data [`ROP_NUM_SLICES];
    logic [`ROP_NUM_SLICES-1:0] slice_mem_rsp_ready;

    rop_req_demux req_demux_i (
        .clk (clk),
        .reset (reset),
        .req_valid (req_valid),
        .req_addr (req_addr),
        .req_color (req_color),
        .req_ready (req_ready),
        .slice_req_valid (slice_req_valid),
        .slice_req_addr (slice_req_addr),
        .slice_req_color (slice_req_color),
        .slice_req_ready (slice_req_ready)
    );

    for (genvar i = 0; i < `ROP_NUM_SLICES; i++) begin : g_slice
        rop_slice slice_i (
            .clk (clk),
            .reset (reset),
            .blend_mode (blend_mode),
            .req_valid (slice_req_valid[i]),
            .req_addr (slice_req_addr[i]),
            .req_color (slice_req_color[i]),
            .req_ready (slice_req_ready[i]),
            .mem_req_valid (slice_mem_req_valid[i]),
            .mem_req_rw (slice_mem_req_rw[i]),
            .mem_req_addr (slice_mem_req_addr[i]),
            .mem_req_data (slice_mem_req_data[i]),
            .mem_req_ready (slice_mem_req_ready[i]),
            .mem_rsp_valid (slice_mem_rsp_valid[i]),
            .mem_rsp_data (slice_mem_rsp_data[i]),
            .mem_rsp_ready (slice_mem_rsp_ready[i])
        );
    end

    rop_mem_mux mem_mux_i (
        .clk (clk),
        .reset (reset),
        .slice_mem_req_valid (slice_mem_req_valid),
        .slice_mem_req_rw (slice_mem_req_rw),
        .slice_mem_req_addr (slice_mem_req_addr),
        .slice_mem_req_data (slice_mem_req_data),
        .slice_mem_req_ready (slice_mem_req_ready),
        .slice_mem_rsp_valid (slice_mem_rsp_valid),
        .slice_mem_rsp_data (slice_mem_rsp_data),
        .slice_mem_rsp_ready (slice_mem_rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_rw (mem_req_rw),
        .mem_req_addr (mem_req_addr),
        .mem_req_data (mem_req_data),
        .mem_req_tag (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data (mem_rsp_data),
        .mem_rsp_tag (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready)
    );

    rop_perf perf_i (
        .clk (clk),
        .reset (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_rw (mem_req_rw),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .perf_mem_reads (perf_mem_reads),
        .perf_mem_writes (perf_mem_writes),
        .perf_mem_latency (perf_mem_latency),
        .perf_idle_cycles (perf_idle_cycles),
        .perf_stall_cycles (perf_stall_cycles)
    );

endmodule

// ==== testbench/rop_mem_model.sv ====
`timescale 1ns/1ps

module rop_mem_model
    import rop_pkg::*;
(
    input logic clk,
    input logic mem_req_valid,
    input logic mem_req_rw,
    input rop_addr_t mem_req_addr,
    input rop_color_t mem_req_data,
    input rop_tag_t mem_req_tag,
    output logic mem_req_ready,
    output logic mem_rsp_valid,
    output rop_color_t mem_rsp_data,
    output rop_tag_t mem_rsp_tag,
    input logic mem_rsp_ready
);

    rop_color_t mem [256];
    rop_color_t rsp_data_q [$];
    rop_tag_t rsp_tag_q [$];
    int rsp_due_q [$];      // cycle from which a queued read may be answered.
    int cycle;
    int seed;
    int write_count;
    int addr_errors;

    // outputs change on the falling edge and the handshake is taken just after.
    initial begin
        int lat;
        seed = 13315;
        cycle = 0;
        write_count = 0;
        addr_errors = 0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        mem_rsp_tag = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'ha5, ~8'(i), 8'(i) + 8'h3c, 8'(i)};
        end
        forever begin
            @(negedge clk);
            cycle++;
            mem_req_ready = ($random(seed) & 3) != 0;   // low about one cycle in four.
            if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data = rsp_data_q[0];
                mem_rsp_tag = rsp_tag_q[0];
            end else begin
                mem_rsp_valid = 1'b0;
            end
            #1;
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req_addr[15:8] != 8'h00) begin
                    addr_errors++;
                    $display("memory model: address 0x%h is outside the 256 word range",
                        mem_req_addr);
                end
                if (mem_req_rw) begin
                    mem[mem_req_addr[7:0]] = mem_req_data;
                    write_count++;
                end else begin
                    lat = 1 + (($random(seed) & 32'h7fff_ffff) % 6);
                    rsp_data_q.push_back(mem[mem_req_addr[7:0]]);
                    rsp_tag_q.push_back(mem_req_tag);
                    rsp_due_q.push_back(cycle + lat);
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_data_q.pop_front());
                void'(rsp_tag_q.pop_front());
                void'(rsp_due_q.pop_front());
            end
        end
    end

endmodule

// ==== testbench/tb_rop_unit.sv ====
`timescale 1ns/1ps

module tb_rop_unit
    import rop_pkg::*;
();

    logic clk;
    logic reset;
    logic req_valid;
    rop_addr_t req_addr;
    rop_color_t req_color;
    logic req_ready;
    rop_blend_t blend_mode;
    logic mem_req_valid;
    logic mem_req_rw;
    rop_addr_t mem_req_addr;
    rop_color_t mem_req_data;
    rop_tag_t mem_req_tag;
    logic mem_req_ready;
    logic mem_rsp_valid;
    rop_color_t mem_rsp_data;
    rop_tag_t mem_rsp_tag;
    logic mem_rsp_ready;
    rop_ctr_t perf_mem_reads;
    rop_ctr_t perf_mem_writes;
    rop_ctr_t perf_mem_latency;
    rop_ctr_t perf_idle_cycles;
    rop_ctr_t perf_stall_cycles;

    rop_color_t shadow [256];   // expected memory contents.
    int seed;
    int n_requests;
    int n_read_requests;
    int n_stall_cycles;
    int value_errors;
    int timeouts;

    rop_unit dut_i (.*);
    rop_mem_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------
    // reference blend and compare tasks.
    // ------------------------------------------------------------

    function automatic rop_color_t blend_expected(rop_blend_t mode, rop_color_t old_c,
                                                  rop_color_t new_c);
        rop_color_t res;
        int s;
        case (mode)
            blend_xor: res = old_c ^ new_c;
            blend_add: begin
                for (int c = 0; c < 4; c++) begin
                    s = int'(old_c[8*c +: 8]) + int'(new_c[8*c +: 8]);
                    res[8*c +: 8] = (s > 255) ? 8'hff : s[7:0];   // clip each channel.
                end
            end
            default: res = new_c;
        endcase
        return res;
    endfunction

    task automatic check_color(input string name, input rop_color_t got, input rop_color_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_ctr(input string name, input rop_ctr_t got, input rop_ctr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_memory();
        for (int i = 0; i < 256; i++) begin
            check_color($sformatf("mem[0x%02h]", i), mem_i.mem[i], shadow[i]);
        end
    endtask

    // ------------------------------------------------------------
    // request driving and drain.
    // ------------------------------------------------------------

    // starts and ends on a falling edge.
    task automatic send_pixel(input rop_addr_t addr, input rop_color_t color);
        int waited;
        waited = 0;
        req_valid = 1'b1;
        req_addr = addr;
        req_color = color;
        #1;
        while (!req_ready && waited < 1000) begin
            n_stall_cycles++;   // the coming rising edge sees valid without ready.
            @(negedge clk);
            #1;
            waited++;
        end
        if (req_ready) begin
            // one address stays in one slice, so acceptance order is memory order.
            shadow[addr[7:0]] = blend_expected(blend_mode, shadow[addr[7:0]], color);
            n_requests++;
            if (blend_mode != blend_replace) n_read_requests++;
        end else begin
            timeouts++;
            $display("timeout: request to address 0x%h was never accepted", addr);
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (mem_i.write_count != n_requests && waited < 2000) begin
            @(negedge clk);
            waited++;
        end
        if (mem_i.write_count != n_requests) begin
            timeouts++;
            $display("timeout: only %0d of %0d pixel writes reached memory",
                mem_i.write_count, n_requests);
        end
    endtask

    // ------------------------------------------------------------
    // directed tests.
    // ------------------------------------------------------------

    task automatic check_after_reset();
        check_flag("req_ready", req_ready, 1'b0);
        check_flag("mem_req_valid", mem_req_valid, 1'b0);
        check_ctr("perf_mem_reads", perf_mem_reads, '0);
        check_ctr("perf_mem_writes", perf_mem_writes, '0);
        check_ctr("perf_mem_latency", perf_mem_latency, '0);
        check_ctr("perf_idle_cycles", perf_idle_cycles, '0);
        check_ctr("perf_stall_cycles", perf_stall_cycles, '0);
    endtask

    task automatic test_replace();
        rop_color_t colors [16];
        blend_mode = blend_replace;
        for (int i = 0; i < 16; i++) begin
            colors[i] = rop_color_t'($random(seed));
            send_pixel(rop_addr_t'(i * 5), colors[i]);
        end
        wait_drain();
        for (int i = 0; i < 16; i++) begin
            check_color($sformatf("mem[0x%02h]", i * 5), mem_i.mem[i * 5], colors[i]);
        end
        check_ctr("perf_mem_reads", perf_mem_reads, '0);   // replace never reads.
    endtask

    task automatic test_add();
        logic [7:0] low;
        blend_mode = blend_replace;
        for (int i = 0; i < 8; i++) begin
            send_pixel(rop_addr_t'(128 + i), {8'hf0, 8'he0 | 8'(i), 8'hfd, 8'h10 + 8'(i)});
        end
        wait_drain();
        blend_mode = blend_add;
        for (int i = 0; i < 8; i++) begin
            send_pixel(rop_addr_t'(128 + i), 32'h3040_0820);
        end
        wait_drain();
        for (int i = 0; i < 8; i++) begin
            low = 8'h30 + 8'(i);    // the only channel that stays below 0xff.
            check_color($sformatf("mem[0x%02h]", 128 + i), mem_i.mem[128 + i],
                {24'hff_ffff, low});
        end
    endtask

    task automatic test_xor();
        rop_color_t acc;
        rop_color_t color;
        blend_mode = blend_xor;
        acc = shadow[200];
        for (int i = 0; i < 8; i++) begin
            color = rop_color_t'($random(seed));
            acc = acc ^ color;
            send_pixel(16'd200, color);
        end
        wait_drain();
        check_color("mem[0xc8]", mem_i.mem[200], acc);
    endtask

    task automatic test_mixed();
        rop_addr_t addr;
        for (int r = 0; r < 4; r++) begin
            case (r)
                0: blend_mode = blend_replace;
                2: blend_mode = blend_xor;
                default: blend_mode = blend_add;
            endcase
            for (int i = 0; i < 24; i++) begin
                addr = rop_addr_t'($random(seed) & 63);
                send_pixel(addr, rop_color_t'($random(seed)));
            end
            wait_drain();
        end
        check_memory();
    endtask

    task automatic test_counters();
        rop_ctr_t idle_before;
        check_ctr("perf_mem_writes", perf_mem_writes, rop_ctr_t'(n_requests));
        check_ctr("perf_mem_reads", perf_mem_reads, rop_ctr_t'(n_read_requests));
        check_ctr("perf_stall_cycles", perf_stall_cycles, rop_ctr_t'(n_stall_cycles));
        if (perf_mem_latency < perf_mem_reads) begin
            value_errors++;     // every read waits at least one cycle.
            $display("** Error: perf_mem_latency = 0x%h, expected at least 0x%h",
                perf_mem_latency, perf_mem_reads);
        end
        idle_before = perf_idle_cycles;
        repeat (20) @(negedge clk);
        check_ctr("perf_idle_cycles growth", perf_idle_cycles - idle_before, 32'd20);
    endtask

    initial begin
        seed = 13315;
        n_requests = 0;
        n_read_requests = 0;
        n_stall_cycles = 0;
        value_errors = 0;
        timeouts = 0;
        reset = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_color = '0;
        blend_mode = blend_replace;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_after_reset();
        for (int i = 0; i < 256; i++) begin
            shadow[i] = mem_i.mem[i];
        end
        test_replace();
        test_add();
        test_xor();
        test_mixed();
        test_counters();
        $display("errors: %0d value, %0d timeout, %0d address",
            value_errors, timeouts, mem_i.addr_errors);
        if (value_errors + timeouts + mem_i.addr_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/rop_pkg.sv
verilog/rop_req_demux.sv
verilog/rop_slice.sv
verilog/rop_mem_mux.sv
verilog/rop_perf.sv
verilog/rop_unit.sv
testbench/rop_mem_model.sv
testbench/tb_rop_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_rop_unit
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST))) verilog/rop_consts.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
